// ==== flist.f ====
dnc_pkg.sv
dnc_matrix_product.sv
dnc_vector_buffer.sv
dnc_vector_summation.sv
dnc_output_vector.sv
dnc_output_vector_tb.sv

// ==== Makefile ====
TOP = dnc_output_vector_tb

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal -f flist.f --top-module $(TOP) -o sim_bin
	./obj_dir/sim_bin | tee sim.log
	grep -q "^Verification passed$$" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== dnc_output_vector_tb.sv ====
/*
  Testbench for the DNC output vector. Random runs with random strobe gaps
  and stray strobes; concurrent assertions compare y against a queue model.
*/
module dnc_output_vector_tb;

  import dnc_pkg::*;

  //////////////////////////////
  // Run setup
  //////////////////////////////

  localparam int MAX_Y    = 8;
  localparam int NUM_RUNS = 20;
  // Worst case per run with l, w and r up to 3 and four cycles per step
  localparam int TIMEOUT_CYCLES = NUM_RUNS * (MAX_Y * 3 * 3 + MAX_Y * 3 + 20) * 4;

  logic                  CLK;
  logic                  RST;
  logic                  START;
  logic                  READY;
  dnc_sizes_t            SIZES;
  logic [DATA_SIZE-1:0]  K_IN;
  logic [DATA_SIZE-1:0]  R_IN;
  logic                  K_IN_ENABLE;
  logic [DATA_SIZE-1:0]  U_IN;
  logic [DATA_SIZE-1:0]  H_IN;
  logic                  U_IN_ENABLE;
  logic [DATA_SIZE-1:0]  Y_OUT;
  logic [SIZE_WIDTH-1:0] Y_OUT_INDEX;
  logic                  Y_OUT_ENABLE;

  // Bookkeeping for the checks
  logic                  new_run;
  logic                  row_end;
  logic                  row_end_d1;
  logic                  row_end_d2;
  logic [SIZE_WIDTH-1:0] out_count;
  logic [DATA_SIZE-1:0]  exp_y [256];
  logic [DATA_SIZE-1:0]  exp_sel;
  logic                  ready_exp;

  // Operand streams of the current run
  logic [DATA_SIZE-1:0]  k_q [$];
  logic [DATA_SIZE-1:0]  r_q [$];
  logic [DATA_SIZE-1:0]  u_q [$];
  logic [DATA_SIZE-1:0]  h_q [$];

  int mismatch_errors = 0;
  int other_errors    = 0;
  int cycle_count     = 0;

  dnc_output_vector #(
    .MAX_Y (MAX_Y)
  ) u_dnc_output_vector (
    .CLK          (CLK),
    .RST          (RST),
    .START        (START),
    .READY        (READY),
    .SIZES        (SIZES),
    .K_IN         (K_IN),
    .R_IN         (R_IN),
    .K_IN_ENABLE  (K_IN_ENABLE),
    .U_IN         (U_IN),
    .H_IN         (H_IN),
    .U_IN_ENABLE  (U_IN_ENABLE),
    .Y_OUT        (Y_OUT),
    .Y_OUT_INDEX  (Y_OUT_INDEX),
    .Y_OUT_ENABLE (Y_OUT_ENABLE)
  );

  always #20 CLK = ~CLK;

  //////////////////////////////
  // Tracking
  //////////////////////////////

  assign exp_sel   = exp_y[Y_OUT_INDEX];
  // READY due in the output slot of the run's last row
  assign ready_exp = row_end_d2 && (out_count == SIZES.size_y - 8'd1);

  // Outputs seen in this run
  always @(posedge CLK or posedge RST) begin
    if (RST) begin
      out_count <= '0;
    end else if (new_run) begin
      out_count <= '0;
    end else if (Y_OUT_ENABLE) begin
      out_count <= out_count + 1'b1;
    end
  end

  // Last U pair of a row delayed to the output slot
  always @(posedge CLK) begin
    row_end_d1 <= row_end;
    row_end_d2 <= row_end_d1;
  end

  //////////////////////////////
  // Checks
  //////////////////////////////

  reset_quiet_check: assert property (@(posedge CLK)
    (RST || $past(RST)) |-> (!READY && !Y_OUT_ENABLE))
    else begin
      other_errors++;
      $display("Error at %0t: READY or Y_OUT_ENABLE high around reset", $time);
    end

  y_value_check: assert property (@(posedge CLK) disable iff (RST)
    Y_OUT_ENABLE |-> (Y_OUT == exp_sel))
    else begin
      mismatch_errors++;
      $display("Mismatch at %0t: Y_OUT got %h expected %h",
               $time, $sampled(Y_OUT), $sampled(exp_sel));
    end

  y_order_check: assert property (@(posedge CLK) disable iff (RST)
    Y_OUT_ENABLE |-> (Y_OUT_INDEX == out_count))
    else begin
      mismatch_errors++;
      $display("Mismatch at %0t: Y_OUT_INDEX got %0d expected %0d",
               $time, $sampled(Y_OUT_INDEX), $sampled(out_count));
    end

  y_count_check: assert property (@(posedge CLK) disable iff (RST)
    Y_OUT_ENABLE |-> (out_count < SIZES.size_y))
    else begin
      other_errors++;
      $display("Error at %0t: more outputs than size_y in one run", $time);
    end

  ready_check: assert property (@(posedge CLK) disable iff (RST)
    (READY == ready_exp))
    else begin
      mismatch_errors++;
      $display("Mismatch at %0t: READY got %b expected %b",
               $time, $sampled(READY), $sampled(ready_exp));
    end

  // Output strobe two cycles after each row's last U pair
  y_timing_check: assert property (@(posedge CLK) disable iff (RST)
    (Y_OUT_ENABLE == row_end_d2))
    else begin
      mismatch_errors++;
      $display("Mismatch at %0t: Y_OUT_ENABLE got %b expected %b",
               $time, $sampled(Y_OUT_ENABLE), $sampled(row_end_d2));
    end

  // Watchdog
  always @(posedge CLK) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("Timeout: runs did not complete within %0d cycles", TIMEOUT_CYCLES);
      $display("Errors: %0d mismatches, %0d other", mismatch_errors, other_errors);
      $display("Verification failed");
      $finish;
    end
  end

  //////////////////////////////
  // Stimulus
  //////////////////////////////

  task automatic clear_strobes();
    START       = 1'b0;
    new_run     = 1'b0;
    K_IN_ENABLE = 1'b0;
    U_IN_ENABLE = 1'b0;
    row_end     = 1'b0;
  endtask

  // 0 to 2 idle cycles with the odd stray strobe of the other stream
  task automatic gap_cycles(input logic stray_u);
    int gap;
    gap = int'($urandom % 3);
    repeat (gap) begin
      @(negedge CLK);
      clear_strobes();
      if ($urandom % 2 == 1) begin
        if (stray_u) begin
          U_IN        = DATA_SIZE'($urandom);
          H_IN        = DATA_SIZE'($urandom);
          U_IN_ENABLE = 1'b1;
        end else begin
          K_IN        = DATA_SIZE'($urandom);
          R_IN        = DATA_SIZE'($urandom);
          K_IN_ENABLE = 1'b1;
        end
      end
    end
  endtask

  // Reference y from the queued pairs with 16 bit wrapping sums
  task automatic compute_expected(input dnc_sizes_t sz);
    int                   row_kr;
    int                   p_kr;
    int                   p_uh;
    logic [DATA_SIZE-1:0] acc;
    row_kr = int'(sz.size_r) * int'(sz.size_w);
    p_kr = 0;
    p_uh = 0;
    for (int y = 0; y < int'(sz.size_y); y++) begin
      acc = '0;
      for (int t = 0; t < row_kr; t++) begin
        acc = acc + k_q[p_kr] * r_q[p_kr];
        p_kr++;
      end
      for (int l = 0; l < int'(sz.size_l); l++) begin
        acc = acc + u_q[p_uh] * h_q[p_uh];
        p_uh++;
      end
      exp_y[SIZE_WIDTH'(y)] = acc;
    end
  endtask

  task automatic run_once(input int run_idx);
    dnc_sizes_t sz;
    int         total_kr;
    int         total_uh;
    sz.size_y = SIZE_WIDTH'(1 + $urandom % MAX_Y);
    sz.size_l = SIZE_WIDTH'(1 + $urandom % 3);
    sz.size_w = SIZE_WIDTH'(1 + $urandom % 3);
    sz.size_r = SIZE_WIDTH'(1 + $urandom % 3);
    total_kr = int'(sz.size_y) * int'(sz.size_r) * int'(sz.size_w);
    total_uh = int'(sz.size_y) * int'(sz.size_l);
    k_q.delete();
    r_q.delete();
    u_q.delete();
    h_q.delete();
    for (int n = 0; n < total_kr; n++) begin
      k_q.push_back(DATA_SIZE'($urandom));
      r_q.push_back(DATA_SIZE'($urandom));
    end
    for (int n = 0; n < total_uh; n++) begin
      u_q.push_back(DATA_SIZE'($urandom));
      h_q.push_back(DATA_SIZE'($urandom));
    end
    compute_expected(sz);

    @(negedge CLK);
    clear_strobes();
    SIZES   = sz;
    START   = 1'b1;
    new_run = 1'b1;

    // K.r pairs in order y then i then k
    for (int n = 0; n < total_kr; n++) begin
      gap_cycles(1'b1);
      @(negedge CLK);
      clear_strobes();
      K_IN        = k_q[n];
      R_IN        = r_q[n];
      K_IN_ENABLE = 1'b1;
      // Extra START while busy
      if (n == 0) begin
        START = 1'b1;
      end
    end

    repeat (2) begin
      @(negedge CLK);
      clear_strobes();
    end

    // U.h pairs in order y then l
    for (int n = 0; n < total_uh; n++) begin
      gap_cycles(1'b0);
      @(negedge CLK);
      clear_strobes();
      U_IN        = u_q[n];
      H_IN        = h_q[n];
      U_IN_ENABLE = 1'b1;
      row_end     = (((n + 1) % int'(sz.size_l)) == 0);
    end

    @(negedge CLK);
    clear_strobes();
    while (!READY) begin
      @(negedge CLK);
    end
    @(negedge CLK);
    run_count_check: assert (out_count == sz.size_y)
      else begin
        mismatch_errors++;
        $display("Mismatch at %0t: output count of run %0d got %0d expected %0d",
                 $time, run_idx, out_count, sz.size_y);
      end
  endtask

  initial begin
    void'($urandom(32'h325f));
    CLK         = 1'b0;
    RST         = 1'b1;
    START       = 1'b0;
    SIZES       = '0;
    K_IN        = '0;
    R_IN        = '0;
    K_IN_ENABLE = 1'b0;
    U_IN        = '0;
    H_IN        = '0;
    U_IN_ENABLE = 1'b0;
    new_run     = 1'b0;
    row_end     = 1'b0;
    row_end_d1  = 1'b0;
    row_end_d2  = 1'b0;
    repeat (3) @(negedge CLK);
    RST = 1'b0;
    repeat (2) @(negedge CLK);

    for (int run = 0; run < NUM_RUNS; run++) begin
      run_once(run);
    end

    repeat (4) @(negedge CLK);
    $display("Errors: %0d mismatches, %0d other", mismatch_errors, other_errors);
    if (mismatch_errors == 0 && other_errors == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

// ==== dnc_output_vector.sv ====
/*
  DNC controller output vector, y = K.r + U.h. Phase FSM routes the
  operand streams through one producer, the row buffer and the consumer.
*/
module dnc_output_vector #(
  parameter int MAX_Y = dnc_pkg::DNC_MAX_Y
) (
  input  logic                            CLK,
  input  logic                            RST,

  // Control
  input  logic                            START,
  output logic                            READY,
  input  dnc_pkg::dnc_sizes_t             SIZES,

  // K.r operand pairs
  input  logic [dnc_pkg::DATA_SIZE-1:0]   K_IN,
  input  logic [dnc_pkg::DATA_SIZE-1:0]   R_IN,
  input  logic                            K_IN_ENABLE,

  // U.h operand pairs
  input  logic [dnc_pkg::DATA_SIZE-1:0]   U_IN,
  input  logic [dnc_pkg::DATA_SIZE-1:0]   H_IN,
  input  logic                            U_IN_ENABLE,

  // Output elements
  output logic [dnc_pkg::DATA_SIZE-1:0]   Y_OUT,
  output logic [dnc_pkg::SIZE_WIDTH-1:0]  Y_OUT_INDEX,
  output logic                            Y_OUT_ENABLE
);

  import dnc_pkg::*;

  //////////////////////////////
  // Signals
  //////////////////////////////

  dnc_state_e      state;
  dnc_state_e      state_next;

  // Producer side
  logic            prod_start;
  dnc_product_op_e prod_op;
  dnc_term_t       prod_term;
  dnc_row_t        prod_row;
  logic            prod_done;

  // Buffer side
  logic            buf_clear;
  dnc_row_t        buf_push;
  logic            buf_pop;
  logic [DATA_SIZE-1:0] buf_head;

  // Consumer side
  logic            sum_start;
  dnc_row_t        sum_row;
  dnc_y_t          sum_y;
  logic            sum_done;

  logic            run_start;

  //////////////////////////////
  // Phase FSM
  //////////////////////////////

  // START only counts while idle
  assign run_start = (state == STARTER_STATE) && START;

  always_comb begin
    state_next = state;
    case (state)
      STARTER_STATE: begin
        if (START) begin
          state_next = FIRST_PRODUCT_STATE;
        end
      end
      FIRST_PRODUCT_STATE: begin
        if (prod_done) begin
          state_next = SECOND_PRODUCT_STATE;
        end
      end
      SECOND_PRODUCT_STATE: begin
        if (prod_done) begin
          state_next = SUMMATION_STATE;
        end
      end
      SUMMATION_STATE: begin
        if (sum_done) begin
          state_next = STARTER_STATE;
        end
      end
      default: state_next = STARTER_STATE;
    endcase
  end

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state <= STARTER_STATE;
    end else begin
      state <= state_next;
    end
  end

  //////////////////////////////
  // Routing
  //////////////////////////////

  // Producer restarts for U.h after the last K.r row
  assign prod_start = run_start || ((state == FIRST_PRODUCT_STATE) && prod_done);
  assign prod_op    = (state == SECOND_PRODUCT_STATE) ? PRODUCT_UH : PRODUCT_KR;
  assign buf_clear  = run_start;
  assign sum_start  = run_start;

  // Operand pair by phase, stray strobes dropped
  always_comb begin
    prod_term.a     = K_IN;
    prod_term.b     = R_IN;
    prod_term.valid = 1'b0;
    if (state == FIRST_PRODUCT_STATE) begin
      prod_term.valid = K_IN_ENABLE;
    end else if (state == SECOND_PRODUCT_STATE) begin
      prod_term.a     = U_IN;
      prod_term.b     = H_IN;
      prod_term.valid = U_IN_ENABLE;
    end
  end

  // K.r rows fill the buffer, U.h rows feed the adder
  assign buf_push.valid = prod_row.valid && (state == FIRST_PRODUCT_STATE);
  assign buf_push.data  = prod_row.data;
  assign sum_row.valid  = prod_row.valid && (state == SECOND_PRODUCT_STATE);
  assign sum_row.data   = prod_row.data;

  //////////////////////////////
  // Datapath
  //////////////////////////////

  dnc_matrix_product u_dnc_matrix_product (
    .CLK   (CLK),
    .RST   (RST),
    .start (prod_start),
    .op    (prod_op),
    .sizes (SIZES),
    .term  (prod_term),
    .row   (prod_row),
    .done  (prod_done)
  );

  dnc_vector_buffer #(
    .MAX_Y (MAX_Y)
  ) u_dnc_vector_buffer (
    .CLK   (CLK),
    .RST   (RST),
    .clear (buf_clear),
    .push  (buf_push),
    .pop   (buf_pop),
    .head  (buf_head)
  );

  dnc_vector_summation u_dnc_vector_summation (
    .CLK    (CLK),
    .RST    (RST),
    .start  (sum_start),
    .size_y (SIZES.size_y),
    .row_in (sum_row),
    .head   (buf_head),
    .pop    (buf_pop),
    .y_out  (sum_y),
    .done   (sum_done)
  );

  // Last element marks the end of the run
  assign READY        = sum_done;
  assign Y_OUT        = sum_y.data;
  assign Y_OUT_INDEX  = sum_y.index;
  assign Y_OUT_ENABLE = sum_y.valid;

endmodule

// ==== dnc_vector_summation.sv ====
/*
  Summation consumer. Adds each incoming U.h row sum to the buffered K.r
  sum and emits the indexed output element one cycle later.
*/
module dnc_vector_summation (
  input  logic                            CLK,
  input  logic                            RST,
  input  logic                            start,
  input  logic [dnc_pkg::SIZE_WIDTH-1:0]  size_y,
  input  dnc_pkg::dnc_row_t               row_in,
  input  logic [dnc_pkg::DATA_SIZE-1:0]   head,
  output logic                            pop,
  output dnc_pkg::dnc_y_t                 y_out,
  output logic                            done
);

  import dnc_pkg::*;

  //////////////////////////////
  // Signals
  //////////////////////////////

  // Index of the next element
  logic [SIZE_WIDTH-1:0] index;
  logic                  last_index;

  logic                  y_valid;
  logic [SIZE_WIDTH-1:0] y_index;
  logic [DATA_SIZE-1:0]  y_data;

  assign last_index = (index == size_y - 1'b1);

  // Buffer entry consumed with each arriving row
  assign pop = row_in.valid;

  //////////////////////////////
  // Index and strobes
  //////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      index   <= '0;
      y_valid <= 1'b0;
      done    <= 1'b0;
    end else begin
      y_valid <= row_in.valid;
      done    <= row_in.valid && last_index;
      if (start) begin
        index <= '0;
      end else if (row_in.valid) begin
        index <= index + 1'b1;
      end
    end
  end

  // Output element, wrapping sum
  always_ff @(posedge CLK) begin
    if (row_in.valid) begin
      y_index <= index;
      y_data  <= head + row_in.data;
    end
  end

  assign y_out.valid = y_valid;
  assign y_out.index = y_index;
  assign y_out.data  = y_data;

endmodule

// ==== dnc_vector_buffer.sv ====
/*
  Circular FIFO holding the K.r row sums until the U.h rows come in.
  The oldest entry shows on head without a clock delay.
*/
module dnc_vector_buffer #(
  parameter int MAX_Y = dnc_pkg::DNC_MAX_Y
) (
  input  logic                           CLK,
  input  logic                           RST,
  input  logic                           clear,
  input  dnc_pkg::dnc_row_t              push,
  input  logic                           pop,
  output logic [dnc_pkg::DATA_SIZE-1:0]  head
);

  import dnc_pkg::*;

  //////////////////////////////
  // Geometry
  //////////////////////////////

  // At least one pointer bit for a single entry
  localparam int PTR_W = (MAX_Y > 1) ? $clog2(MAX_Y) : 1;
  localparam logic [PTR_W-1:0] LAST_PTR = PTR_W'(MAX_Y - 1);

  //////////////////////////////
  // Storage
  //////////////////////////////

  logic [DATA_SIZE-1:0] mem [MAX_Y];
  logic [PTR_W-1:0]     wr_ptr;
  logic [PTR_W-1:0]     rd_ptr;

  // Next pointer with wrap for any depth
  function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
    logic [PTR_W-1:0] nxt;
    if (ptr == LAST_PTR) begin
      nxt = '0;
    end else begin
      nxt = ptr + 1'b1;
    end
    return nxt;
  endfunction

  //////////////////////////////
  // Pointers
  //////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else if (clear) begin
      // New run starts empty
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (push.valid) begin
        wr_ptr <= ptr_inc(wr_ptr);
      end
      if (pop) begin
        rd_ptr <= ptr_inc(rd_ptr);
      end
    end
  end

  // Entry write
  always_ff @(posedge CLK) begin
    if (push.valid) begin
      mem[wr_ptr] <= push.data;
    end
  end

  // Head of queue, read by consumer in the popping cycle
  assign head = mem[rd_ptr];

endmodule

// ==== dnc_matrix_product.sv ====
/*
  Multiply-accumulate producer. Reduces a stream of operand pairs into one
  dot product per output row; row length follows op and sizes.
*/
module dnc_matrix_product (
  input  logic                        CLK,
  input  logic                        RST,
  input  logic                        start,
  input  dnc_pkg::dnc_product_op_e    op,
  input  dnc_pkg::dnc_sizes_t         sizes,
  input  dnc_pkg::dnc_term_t          term,
  output dnc_pkg::dnc_row_t           row,
  output logic                        done
);

  import dnc_pkg::*;

  //////////////////////////////
  // Signals
  //////////////////////////////

  // Terms per row, up to size_r*size_w
  logic [2*SIZE_WIDTH-1:0] row_len;
  logic [2*SIZE_WIDTH-1:0] term_cnt;
  logic [SIZE_WIDTH-1:0]   row_cnt;

  logic [DATA_SIZE-1:0]    acc;
  logic [DATA_SIZE-1:0]    product;
  logic [DATA_SIZE-1:0]    acc_sum;

  logic                    last_term;
  logic                    last_row;

  logic                    row_valid;
  logic [DATA_SIZE-1:0]    row_data;

  //////////////////////////////
  // Row geometry
  //////////////////////////////

  // K.r rows span all i and k, U.h rows span l
  always_comb begin
    if (op == PRODUCT_KR) begin
      row_len = sizes.size_r * sizes.size_w;
    end else begin
      row_len = {{SIZE_WIDTH{1'b0}}, sizes.size_l};
    end
  end

  assign last_term = (term_cnt == row_len - 1'b1);
  assign last_row  = (row_cnt == sizes.size_y - 1'b1);

  // Wraps at DATA_SIZE bits
  assign product = term.a * term.b;
  assign acc_sum = acc + product;

  //////////////////////////////
  // Counters and strobes
  //////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      term_cnt  <= '0;
      row_cnt   <= '0;
      acc       <= '0;
      row_valid <= 1'b0;
      done      <= 1'b0;
    end else begin
      row_valid <= 1'b0;
      done      <= 1'b0;
      // Start wins over a term in the same cycle
      if (start) begin
        term_cnt <= '0;
        row_cnt  <= '0;
        acc      <= '0;
      end else if (term.valid) begin
        if (last_term) begin
          // Row complete, restart accumulation
          term_cnt  <= '0;
          acc       <= '0;
          row_valid <= 1'b1;
          done      <= last_row;
          row_cnt   <= last_row ? '0 : row_cnt + 1'b1;
        end else begin
          term_cnt <= term_cnt + 1'b1;
          acc      <= acc_sum;
        end
      end
    end
  end

  // Finished row sum
  always_ff @(posedge CLK) begin
    if (!start && term.valid && last_term) begin
      row_data <= acc_sum;
    end
  end

  assign row.valid = row_valid;
  assign row.data  = row_data;

endmodule

// ==== dnc_pkg.sv ====
/*
  Shared widths, bundles and enums for the DNC output vector datapath.
  Imported by every module of the subsystem.
*/
package dnc_pkg;

  //////////////////////////////
  // Widths
  //////////////////////////////

  // Operands, row sums and outputs
  localparam int DATA_SIZE = 16;

  // Dimension sizes and output index
  localparam int SIZE_WIDTH = 8;

  // Default buffer depth, largest size_y handled
  localparam int DNC_MAX_Y = 8;

  //////////////////////////////
  // Bundles
  //////////////////////////////

  // Problem dimensions, stable from START until READY
  typedef struct packed {
    logic [SIZE_WIDTH-1:0] size_y;
    logic [SIZE_WIDTH-1:0] size_l;
    logic [SIZE_WIDTH-1:0] size_w;
    logic [SIZE_WIDTH-1:0] size_r;
  } dnc_sizes_t;

  // One operand pair with its strobe
  typedef struct packed {
    logic                 valid;
    logic [DATA_SIZE-1:0] a;
    logic [DATA_SIZE-1:0] b;
  } dnc_term_t;

  // One finished dot product
  typedef struct packed {
    logic                 valid;
    logic [DATA_SIZE-1:0] data;
  } dnc_row_t;

  // One element of the output vector
  typedef struct packed {
    logic                  valid;
    logic [SIZE_WIDTH-1:0] index;
    logic [DATA_SIZE-1:0]  data;
  } dnc_y_t;

  //////////////////////////////
  // Enums
  //////////////////////////////

  // Which product the producer is reducing
  typedef enum logic [0:0] {
    PRODUCT_KR,
    PRODUCT_UH
  } dnc_product_op_e;

  // Top level controller
  typedef enum logic [1:0] {
    STARTER_STATE,
    FIRST_PRODUCT_STATE,
    SECOND_PRODUCT_STATE,
    SUMMATION_STATE
  } dnc_state_e;

endpackage
